// File: Makefile
VERILATOR ?= verilator
TOP       ?= mtcore_tb
FILELIST  ?= mtcore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/decode.sv
// decode: field extraction and control generation for one fetched instruction word
`default_nettype none

`include "mtcore_defines.svh"

module decode import mtcore_pkg::*; (
    input  wire fetch_item_t                     ins,
    output logic [$clog2(`MT_REGS)-1:0]          reg_rd_a,
    output logic [$clog2(`MT_REGS)-1:0]          reg_rd_b,
    output logic [$clog2(`MT_REGS)-1:0]          reg_wr,
    output logic [15:0]                          imm,
    output logic                                 wr_en,
    output alu_op_e                              alu_op,
    output logic                                 i_type,
    output thread_ctrl_t                         thread_ctrl,
    output logic                                 invalid
);

    localparam int TW = $clog2(`MT_THREADS);

    opcode_e                      op;
    logic [$clog2(`MT_REGS)-1:0]  rt;
    logic [$clog2(`MT_REGS)-1:0]  rd;

    // op[31:26] rs[25:21] rt[20:16] rd[15:11] imm[15:0]
    assign op       = opcode_e'(ins.ins[31:26]);
    assign reg_rd_a = ins.ins[25:21];
    assign rt       = ins.ins[20:16];
    assign rd       = ins.ins[15:11];
    assign reg_rd_b = rt;
    assign imm      = ins.ins[15:0];

    always_comb begin
        reg_wr      = rd;
        wr_en       = 1'b0;
        alu_op      = ALU_ADD;
        i_type      = 1'b0;
        invalid     = 1'b0;
        thread_ctrl = '0;
        case (op)
            OP_NOP: ;
            OP_ADD: begin
                wr_en  = 1'b1;
                alu_op = ALU_ADD;
            end
            OP_SUB: begin
                wr_en  = 1'b1;
                alu_op = ALU_SUB;
            end
            OP_AND: begin
                wr_en  = 1'b1;
                alu_op = ALU_AND;
            end
            OP_OR: begin
                wr_en  = 1'b1;
                alu_op = ALU_OR;
            end
            OP_XOR: begin
                wr_en  = 1'b1;
                alu_op = ALU_XOR;
            end
            OP_ADDI, OP_LUI: begin
                reg_wr = rt;
                wr_en  = 1'b1;
                i_type = 1'b1;
                alu_op = (op == OP_LUI) ? ALU_LUI : ALU_ADD;
            end
            OP_SPAWN: begin
                thread_ctrl.spawn    = ins.valid;
                thread_ctrl.tid      = rt[TW-1:0];
                thread_ctrl.start_pc = `MT_XLEN'({imm, 2'b00});
            end
            // halt always targets the issuing thread
            OP_HALT: begin
                thread_ctrl.halt = ins.valid;
                thread_ctrl.tid  = ins.tid;
            end
            default: invalid = 1'b1;
        endcase
        if (reg_wr == '0) begin
            wr_en = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/execute.sv
// execute: ALU, register file write record and the registered writeback record
`default_nettype none

`include "mtcore_defines.svh"

module execute import mtcore_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire dec_item_t     dec_item,
    output wb_item_t           wr_item,
    output wb_item_t           wb_item
);

    logic [`MT_XLEN-1:0]  imm_sx;
    logic [`MT_XLEN-1:0]  opnd_b;
    logic [`MT_XLEN-1:0]  result;

    assign imm_sx = {{(`MT_XLEN-16){dec_item.imm[15]}}, dec_item.imm};
    assign opnd_b = dec_item.i_type ? imm_sx : dec_item.op_b;

    always_comb begin
        case (dec_item.alu_op)
            ALU_ADD: result = dec_item.op_a + opnd_b;
            ALU_SUB: result = dec_item.op_a - opnd_b;
            ALU_AND: result = dec_item.op_a & opnd_b;
            ALU_OR:  result = dec_item.op_a | opnd_b;
            ALU_XOR: result = dec_item.op_a ^ opnd_b;
            ALU_LUI: result = `MT_XLEN'({dec_item.imm, 16'h0000});
            default: result = '0;
        endcase
    end

    // the register file takes this record in the same cycle and bypasses it to the decode reads
    always_comb begin
        wr_item.valid = dec_item.valid;
        wr_item.tid   = dec_item.tid;
        wr_item.pc    = dec_item.pc;
        wr_item.ins   = dec_item.ins;
        wr_item.rd    = dec_item.rd;
        wr_item.wr_en = dec_item.valid & dec_item.wr_en;
        wr_item.data  = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_item <= '0;
        end else begin
            wb_item <= wr_item;
        end
    end

endmodule

`default_nettype wire

// File: hw/insdec.sv
// insdec: decode/register stage holding the dec/exe pipeline register
`default_nettype none

`include "mtcore_defines.svh"

module insdec import mtcore_pkg::*; (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire fetch_item_t    fetch_item,
    input  wire wb_item_t       wb,
    output thread_ctrl_t        thread_ctrl,
    output dec_item_t           dec_item,
    output logic                invalid_op
);

    logic [$clog2(`MT_REGS)-1:0]  reg_rd_a;
    logic [$clog2(`MT_REGS)-1:0]  reg_rd_b;
    logic [$clog2(`MT_REGS)-1:0]  reg_wr;
    logic [15:0]                  imm;
    logic                         wr_en;
    alu_op_e                      alu_op;
    logic                         i_type;
    logic                         invalid;
    logic [`MT_XLEN-1:0]          data_a;
    logic [`MT_XLEN-1:0]          data_b;

    decode decode_inst (
        .ins         (fetch_item),
        .reg_rd_a    (reg_rd_a),
        .reg_rd_b    (reg_rd_b),
        .reg_wr      (reg_wr),
        .imm         (imm),
        .wr_en       (wr_en),
        .alu_op      (alu_op),
        .i_type      (i_type),
        .thread_ctrl (thread_ctrl),
        .invalid     (invalid)
    );

    // a spawn clears the target thread's registers at the next edge
    regfile_set regfile_set_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_trd    (fetch_item.tid),
        .rd_reg_a  (reg_rd_a),
        .rd_reg_b  (reg_rd_b),
        .wr_trd    (wb.tid),
        .wr_reg    (wb.rd),
        .wr_data   (wb.data),
        .wr_en     (wb.wr_en),
        .init      (thread_ctrl.spawn),
        .init_trd  (thread_ctrl.tid),
        .rd_data_a (data_a),
        .rd_data_b (data_b)
    );

    // ########################################
    // dec/exe pipeline register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_item   <= '0;
            invalid_op <= 1'b0;
        end else begin
            dec_item.valid  <= fetch_item.valid;
            dec_item.tid    <= fetch_item.tid;
            dec_item.pc     <= fetch_item.pc;
            dec_item.ins    <= fetch_item.ins;
            dec_item.op_a   <= data_a;
            dec_item.op_b   <= data_b;
            dec_item.rd     <= reg_wr;
            dec_item.alu_op <= alu_op;
            dec_item.imm    <= imm;
            dec_item.i_type <= i_type;
            dec_item.wr_en  <= fetch_item.valid & wr_en;
            invalid_op      <= fetch_item.valid & invalid;
        end
    end

endmodule

`default_nettype wire

// File: hw/mtcore_defines.svh
// mtcore configuration macros for thread count, register file size and memory depth
`ifndef MTCORE_DEFINES_SVH
`define MTCORE_DEFINES_SVH

// hardware threads sharing the pipeline
`define MT_THREADS 8

// architectural registers per thread with r0 reading as zero
`define MT_REGS 32

// data path and instruction word width
`define MT_XLEN 32

// instruction memory depth in 32-bit words
`define MT_IMEM_WORDS 256

`endif

// File: hw/mtcore_pkg.sv
// mtcore shared types: opcodes, alu operations and the records passed between stages
`default_nettype none

`include "mtcore_defines.svh"

package mtcore_pkg;

    // opcode in ins[31:26] where any unlisted value is invalid
    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_ADDI  = 6'd6,
        OP_LUI   = 6'd7,
        OP_SPAWN = 6'd8,
        OP_HALT  = 6'd9
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_e;

    // ########################################
    // stage records

    typedef struct packed {
        logic                             valid;
        logic [$clog2(`MT_THREADS)-1:0]   tid;
        logic [`MT_XLEN-1:0]              pc;
        logic [`MT_XLEN-1:0]              ins;
    } fetch_item_t;

    typedef struct packed {
        logic                             valid;
        logic [$clog2(`MT_THREADS)-1:0]   tid;
        logic [`MT_XLEN-1:0]              pc;
        logic [`MT_XLEN-1:0]              ins;
        logic [`MT_XLEN-1:0]              op_a;
        logic [`MT_XLEN-1:0]              op_b;
        logic [$clog2(`MT_REGS)-1:0]      rd;
        alu_op_e                          alu_op;
        logic [15:0]                      imm;
        logic                             i_type;
        logic                             wr_en;
    } dec_item_t;

    typedef struct packed {
        logic                             valid;
        logic [$clog2(`MT_THREADS)-1:0]   tid;
        logic [`MT_XLEN-1:0]              pc;
        logic [`MT_XLEN-1:0]              ins;
        logic [$clog2(`MT_REGS)-1:0]      rd;
        logic                             wr_en;
        logic [`MT_XLEN-1:0]              data;
    } wb_item_t;

    // spawn and halt requests from decode
    typedef struct packed {
        logic                             spawn;
        logic                             halt;
        logic [$clog2(`MT_THREADS)-1:0]   tid;
        logic [`MT_XLEN-1:0]              start_pc;
    } thread_ctrl_t;

endpackage

`default_nettype wire

// File: hw/mtcore_top.sv
// mtcore_top: multithreaded pipeline joining fetch, decode/register and execute stages
`default_nettype none

`include "mtcore_defines.svh"

module mtcore_top import mtcore_pkg::*; (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                imem_we,
    input  wire logic [$clog2(`MT_IMEM_WORDS)-1:0]   imem_addr,
    input  wire logic [`MT_XLEN-1:0]                 imem_data,
    output wb_item_t                                 wb_item,
    output logic                                     invalid_op,
    output logic [`MT_THREADS-1:0]                   active_mask
);

    fetch_item_t   fetch_item;
    dec_item_t     dec_item;
    thread_ctrl_t  thread_ctrl;
    wb_item_t      wr_item;

    thread_fetch thread_fetch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .thread_ctrl (thread_ctrl),
        .fetch_item  (fetch_item),
        .active_mask (active_mask)
    );

    insdec insdec_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_item  (fetch_item),
        .wb          (wr_item),
        .thread_ctrl (thread_ctrl),
        .dec_item    (dec_item),
        .invalid_op  (invalid_op)
    );

    execute execute_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec_item (dec_item),
        .wr_item  (wr_item),
        .wb_item  (wb_item)
    );

endmodule

`default_nettype wire

// File: hw/regfile_set.sv
// regfile_set: one register file per thread, two read ports, bypassed write port, thread clear
`default_nettype none

`include "mtcore_defines.svh"

module regfile_set (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [$clog2(`MT_THREADS)-1:0]      rd_trd,
    input  wire logic [$clog2(`MT_REGS)-1:0]         rd_reg_a,
    input  wire logic [$clog2(`MT_REGS)-1:0]         rd_reg_b,
    input  wire logic [$clog2(`MT_THREADS)-1:0]      wr_trd,
    input  wire logic [$clog2(`MT_REGS)-1:0]         wr_reg,
    input  wire logic [`MT_XLEN-1:0]                 wr_data,
    input  wire logic                                wr_en,
    input  wire logic                                init,
    input  wire logic [$clog2(`MT_THREADS)-1:0]      init_trd,
    output logic [`MT_XLEN-1:0]                      rd_data_a,
    output logic [`MT_XLEN-1:0]                      rd_data_b
);

    localparam int RW = $clog2(`MT_REGS);

    logic [`MT_XLEN-1:0]  mem [`MT_THREADS][`MT_REGS];
    logic [`MT_REGS-1:0]  vld [`MT_THREADS];

    // r0, bypass, then stored value; never-written registers read zero
    function automatic logic [`MT_XLEN-1:0] read_port(input logic [RW-1:0] r);
        if (r == '0) begin
            return '0;
        end else if (wr_en && wr_trd == rd_trd && wr_reg == r) begin
            return wr_data;
        end else if (vld[rd_trd][r]) begin
            return mem[rd_trd][r];
        end
        return '0;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_trd][wr_reg] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MT_THREADS; i++) begin
                vld[i] <= '0;
            end
        end else begin
            if (init) begin
                vld[init_trd] <= '0;
            end
            if (wr_en) begin
                vld[wr_trd][wr_reg] <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_data_a = read_port(rd_reg_a);
        rd_data_b = read_port(rd_reg_b);
    end

endmodule

`default_nettype wire

// File: hw/thread_fetch.sv
// thread_fetch: per-thread pcs, active mask, round-robin thread pick and instruction memory
`default_nettype none

`include "mtcore_defines.svh"

module thread_fetch import mtcore_pkg::*; (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                imem_we,
    input  wire logic [$clog2(`MT_IMEM_WORDS)-1:0]   imem_addr,
    input  wire logic [`MT_XLEN-1:0]                 imem_data,
    input  wire thread_ctrl_t                        thread_ctrl,
    output fetch_item_t                              fetch_item,
    output logic [`MT_THREADS-1:0]                   active_mask
);

    localparam int TW = $clog2(`MT_THREADS);
    localparam int AW = $clog2(`MT_IMEM_WORDS);

    logic [`MT_XLEN-1:0]     imem [`MT_IMEM_WORDS];
    logic [`MT_XLEN-1:0]     pc [`MT_THREADS];
    logic [`MT_THREADS-1:0]  halt_mask;
    logic [`MT_THREADS-1:0]  eligible;
    logic [TW-1:0]           last_tid;
    logic [TW-1:0]           pick;
    logic                    found;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    // a halting thread drops out of this cycle's pick already
    always_comb begin
        halt_mask = '0;
        if (thread_ctrl.halt) begin
            halt_mask[thread_ctrl.tid] = 1'b1;
        end
        eligible = active_mask & ~halt_mask;
    end

    // search starts at the thread after the last one chosen
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last_tid;
        for (int i = 1; i <= `MT_THREADS; i++) begin
            idx = (int'(last_tid) + i) % `MT_THREADS;
            if (!found && eligible[idx]) begin
                found = 1'b1;
                pick  = TW'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_mask <= `MT_THREADS'(1);
            last_tid    <= TW'(`MT_THREADS - 1);
            fetch_item  <= '0;
            for (int i = 0; i < `MT_THREADS; i++) begin
                pc[i] <= '0;
            end
        end else begin
            fetch_item.valid <= found;
            active_mask      <= eligible;
            if (found) begin
                fetch_item.tid <= pick;
                fetch_item.pc  <= pc[pick];
                fetch_item.ins <= imem[pc[pick][AW+1:2]];
                pc[pick]       <= pc[pick] + `MT_XLEN'(4);
                last_tid       <= pick;
            end
            // spawn overrides the increment when it targets the picked thread
            if (thread_ctrl.spawn) begin
                active_mask[thread_ctrl.tid] <= 1'b1;
                pc[thread_ctrl.tid]          <= thread_ctrl.start_pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: mtcore.f
+incdir+hw
hw/mtcore_pkg.sv
hw/thread_fetch.sv
hw/regfile_set.sv
hw/decode.sv
hw/insdec.sv
hw/execute.sv
hw/mtcore_top.sv
verification/mtcore_props.sv
verification/mtcore_tb.sv

// File: verification/mtcore_props.sv
// mtcore_props: concurrent assertions on the writeback record, invalid_op pulse and thread mask
`default_nettype none

`include "mtcore_defines.svh"

module mtcore_props import mtcore_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire wb_item_t                    wb_item,
    input  wire logic                        invalid_op,
    input  wire logic [`MT_THREADS-1:0]      active_mask
);

    int unsigned fail_count = 0;

    // invalid_op leads its own writeback record by one cycle and lasts one cycle
    invalid_lead_a: assert property (@(posedge clk) disable iff (!rst_n)
        invalid_op |=> wb_item.valid && !wb_item.wr_en && (wb_item.ins[31:26] > 6'd9))
    else begin
        fail_count++;
        $error("invalid_op not followed by an invalid writeback record");
    end

    invalid_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        invalid_op |=> !invalid_op)
    else begin
        fail_count++;
        $error("invalid_op held longer than one cycle");
    end

    no_r0_write_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_item.wr_en |-> wb_item.valid && (wb_item.rd != '0))
    else begin
        fail_count++;
        $error("register write to r0 or without a valid record");
    end

    // a halted thread is already gone from the mask when its HALT is written back
    halt_mask_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_item.valid && (wb_item.ins[31:26] == OP_HALT) |-> !active_mask[wb_item.tid])
    else begin
        fail_count++;
        $error("thread still active after its halt reached writeback");
    end

    // the thread was in the mask in the cycle its instruction was fetched
    live_mask_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_item.valid |->
            ($past(active_mask, 3) & (`MT_THREADS'(1) << wb_item.tid)) != '0)
    else begin
        fail_count++;
        $error("writeback record from a thread outside the active mask");
    end

    idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        (active_mask == '0) |=> ##1 !wb_item.valid)
    else begin
        fail_count++;
        $error("writeback record after every thread stopped");
    end

endmodule

bind mtcore_top mtcore_props props_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_item     (wb_item),
    .invalid_op  (invalid_op),
    .active_mask (active_mask)
);

`default_nettype wire

// File: verification/mtcore_tb.sv
// mtcore_tb: testbench running a multithreaded program against a per-thread register model
`default_nettype none

`include "mtcore_defines.svh"

module mtcore_tb import mtcore_pkg::*; ();

    localparam int NT = `MT_THREADS;
    localparam int AW = $clog2(`MT_IMEM_WORDS);
    localparam int PROG_WORDS = 80;

    logic                  clk;
    logic                  rst_n;
    logic                  imem_we;
    logic [AW-1:0]         imem_addr;
    logic [`MT_XLEN-1:0]   imem_data;
    wb_item_t              wb_item;
    logic                  invalid_op;
    logic [NT-1:0]         active_mask;

    logic [31:0]   prog [PROG_WORDS];
    int            wp;
    logic [31:0]   rng;
    logic [31:0]   model [NT][`MT_REGS];
    logic [31:0]   start_pc [NT];
    logic [31:0]   last_pc [NT];
    logic [NT-1:0] seen;
    logic [NT-1:0] running;
    logic [NT-1:0] pending;
    logic [NT-1:0] halted;
    int            prev_tid;
    logic          prev_invalid;
    int            halts;

    mtcore_top mtcore_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .wb_item     (wb_item),
        .invalid_op  (invalid_op),
        .active_mask (active_mask)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ########################################
    // reporting

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("error at time %0t: %s", $time, what);
        abort_run();
    endtask

    // ########################################
    // program generation

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] next_imm();
        rng = xorshift32(rng);
        return rng[15:0];
    endfunction

    function automatic logic [31:0] enc_r(input opcode_e op, input int rs, input int rt,
                                          input int rd);
        return {op, 5'(rs), 5'(rt), 5'(rd), 11'h000};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[wp] = w;
        wp++;
    endtask

    // r20 reads registers that only thread 0 has written and must come out zero
    task automatic spawned_code(input int base);
        wp = base;
        emit(enc_r(OP_ADD, 1, 3, 20));
        emit(enc_i(OP_ADDI, 0, 1, next_imm()));
        emit(enc_i(OP_ADDI, 1, 3, next_imm()));
        emit(enc_i(OP_LUI, 0, 4, next_imm()));
        emit(enc_r(OP_ADD, 1, 3, 5));
        emit(enc_r(OP_SUB, 5, 4, 6));
        emit(enc_r(OP_AND, 6, 1, 7));
        emit(enc_r(OP_OR, 7, 3, 8));
        emit(enc_r(OP_XOR, 8, 5, 9));
        emit(enc_i(OP_ADDI, 9, 10, 16'h8000));
        emit(enc_r(OP_HALT, 0, 0, 0));
    endtask

    task automatic build_program();
        for (int a = 0; a < PROG_WORDS; a++) begin
            prog[a] = {OP_NOP, 10'h155, 16'(a) ^ 16'h5a5a};
        end
        wp = 0;
        emit(enc_i(OP_ADDI, 0, 1, 16'h1234));
        emit(enc_i(OP_LUI, 0, 2, 16'habcd));
        for (int r = 3; r <= 6; r++) begin
            emit(enc_i(OP_ADDI, 0, r, next_imm()));
        end
        emit(enc_r(OP_ADD, 1, 3, 7));
        emit(enc_r(OP_SUB, 7, 2, 8));
        emit(enc_r(OP_AND, 8, 4, 9));
        emit(enc_r(OP_OR, 9, 5, 10));
        emit(enc_r(OP_XOR, 10, 6, 11));
        emit(enc_i(OP_ADDI, 1, 0, 16'h0005));
        emit(enc_r(OP_ADD, 0, 1, 12));
        emit({6'h3f, 26'h0});
        emit(enc_i(OP_SPAWN, 0, 1, 16'd32));
        emit(enc_i(OP_SPAWN, 0, 2, 16'd48));
        emit(enc_i(OP_SPAWN, 0, 3, 16'd64));
        emit(enc_r(OP_ADD, 11, 12, 13));
        emit(enc_r(OP_SUB, 13, 13, 14));
        emit(enc_i(OP_ADDI, 14, 15, 16'hffff));
        emit(enc_r(OP_XOR, 15, 11, 16));
        emit(enc_r(OP_NOP, 0, 0, 0));
        emit(enc_r(OP_HALT, 0, 0, 0));
        spawned_code(32);
        spawned_code(48);
        spawned_code(64);
    endtask

    task automatic load_program();
        for (int a = 0; a < PROG_WORDS; a++) begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = AW'(a);
            imem_data = prog[a];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic reset_model();
        for (int t = 0; t < NT; t++) begin
            for (int r = 0; r < `MT_REGS; r++) begin
                model[t][r] = '0;
            end
            start_pc[t] = '0;
            last_pc[t]  = '0;
        end
        seen         = '0;
        running      = NT'(1);
        pending      = '0;
        halted       = '0;
        prev_tid     = NT - 1;
        prev_invalid = 1'b0;
        halts        = 0;
    endtask

    // ########################################
    // reference model and checks

    function automatic int next_running(input int prev, input logic [NT-1:0] run);
        int t;
        for (int i = 1; i <= NT; i++) begin
            t = (prev + i) % NT;
            if (run[t]) begin
                return t;
            end
        end
        return -1;
    endfunction

    task automatic check_item();
        int          tid;
        int          exp_tid;
        int          tgt;
        int          dest;
        int          word;
        logic [5:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] exp;
        logic [31:0] exp_pc;
        logic        exp_wr;
        tid     = int'(wb_item.tid);
        op      = wb_item.ins[31:26];
        a       = model[tid][wb_item.ins[25:21]];
        b       = model[tid][wb_item.ins[20:16]];
        sx      = {{16{wb_item.ins[15]}}, wb_item.ins[15:0]};
        dest    = int'(wb_item.ins[15:11]);
        exp_tid = next_running(prev_tid, running);
        assert (!halted[tid]) else report_problem("writeback record from a halted thread");
        assert (tid == exp_tid) else report_mismatch("wb_item.tid", 32'(tid), 32'(exp_tid));
        if (seen[tid]) begin
            exp_pc = last_pc[tid] + 32'd4;
        end else begin
            exp_pc = start_pc[tid];
        end
        assert (wb_item.pc == exp_pc) else report_mismatch("wb_item.pc", wb_item.pc, exp_pc);
        word = int'(exp_pc >> 2);
        assert (wb_item.ins == prog[word])
        else report_mismatch("wb_item.ins", wb_item.ins, prog[word]);
        seen[tid]    = 1'b1;
        last_pc[tid] = wb_item.pc;
        prev_tid     = tid;
        case (op)
            OP_ADD:  exp = a + b;
            OP_SUB:  exp = a - b;
            OP_AND:  exp = a & b;
            OP_OR:   exp = a | b;
            OP_XOR:  exp = a ^ b;
            OP_ADDI: exp = a + sx;
            OP_LUI:  exp = {wb_item.ins[15:0], 16'h0000};
            default: exp = '0;
        endcase
        if (op == OP_ADDI || op == OP_LUI) begin
            dest = int'(wb_item.ins[20:16]);
        end
        exp_wr = (op >= 6'd1) && (op <= 6'd7) && (dest != 0);
        assert (wb_item.wr_en == exp_wr)
        else report_mismatch("wb_item.wr_en", 32'(wb_item.wr_en), 32'(exp_wr));
        if (exp_wr) begin
            assert (int'(wb_item.rd) == dest)
            else report_mismatch("wb_item.rd", 32'(wb_item.rd), 32'(dest));
            assert (wb_item.data == exp) else report_mismatch("wb_item.data", wb_item.data, exp);
            model[tid][dest] = exp;
        end
        // a spawned thread joins the rotation one record after its SPAWN
        running = running | pending;
        pending = '0;
        if (op == OP_SPAWN) begin
            tgt = int'(wb_item.ins[18:16]);
            for (int r = 0; r < `MT_REGS; r++) begin
                model[tgt][r] = '0;
            end
            start_pc[tgt] = {14'h0, wb_item.ins[15:0], 2'b00};
            seen[tgt]     = 1'b0;
            halted[tgt]   = 1'b0;
            pending[tgt]  = 1'b1;
        end
        if (op == OP_HALT) begin
            running[tid] = 1'b0;
            halted[tid]  = 1'b1;
            halts++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            assert ((wb_item.valid && wb_item.ins[31:26] > 6'd9) == prev_invalid)
            else report_mismatch("invalid_op one cycle earlier", 32'(prev_invalid),
                                 32'(wb_item.valid && wb_item.ins[31:26] > 6'd9));
            if (wb_item.valid) begin
                check_item();
            end
            prev_invalid = invalid_op;
        end
    end

    always @(negedge clk) begin
        if (mtcore_top_inst.props_inst.fail_count != 0) begin
            report_problem("a concurrent assertion in mtcore_props failed");
        end
    end

    // watchdog of 20 cycles per program word plus 200
    initial begin
        #((20 * PROG_WORDS + 200) * 10);
        report_problem("timeout, the threads did not all halt in time");
    end

    initial begin
        rst_n     = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        rng       = 32'hca9c_e80a;
        reset_model();
        build_program();
        load_program();
        // reset held for 10 cycles after the load
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        wait (halts > 0 && running == '0 && pending == '0);
        repeat (10) begin
            @(negedge clk);
            assert (!wb_item.valid) else report_problem("writeback record after all threads halted");
        end
        assert (active_mask == '0) else report_mismatch("active_mask", 32'(active_mask), 32'h0);
        if (mtcore_top_inst.props_inst.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire
